//--- flist.f
+incdir+include
src/itch_msg_pkg.sv
src/order_pkg.sv
src/itch_framer.sv
src/itch_field_extract.sv
src/itch_order_out.sv
src/itch_parser_top.sv
tb/tb_itch_parser.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ITCH parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_itch_parser -f flist.f \
    -o tb_itch_parser || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/tb_itch_parser)
echo "$sim_out"

echo "$sim_out" | grep -qx "NO ERRORS" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- src/itch_field_extract.sv
`timescale 1ns/1ps
`default_nettype none

module itch_field_extract (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     byte_strobe_i,
    input  wire logic [7:0]               byte_offset_i,
    input  wire itch_msg_pkg::msg_kind_t  msg_kind_i,
    input  wire logic                     msg_start_i,
    input  wire logic                     msg_done_i,
    input  wire logic [7:0]               data_i,
    output order_pkg::order_rec_t         rec_o,
    output logic                          rec_load_o
);
    import itch_msg_pkg::*;
    import order_pkg::*;

    logic [7:0] byte_q;  // Byte consumed in the previous cycle
    logic       is_add;
    logic       is_exec;
    logic       sel_ref;
    logic       sel_side;
    logic       sel_shares;
    logic       sel_stock;
    logic       sel_price;

    // Offset falls inside the four-byte field starting at base
    function automatic logic in_field(input logic [7:0] off, input logic [7:0] base);
        logic [7:0] rel;
        rel = off - base;
        return rel < field_bytes;
    endfunction

    function automatic order_type_t type_of_kind(input msg_kind_t kind);
        case (kind)
            kind_add_a, kind_add_f:   return ord_add;
            kind_exec_e, kind_exec_c: return ord_execute;
            kind_cancel_x:            return ord_cancel;
            kind_delete_d:            return ord_delete;
            default:                  return ord_error;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Field select by kind and offset
    //////////////////////////////////////////////////

    assign is_add  = (msg_kind_i == kind_add_a) || (msg_kind_i == kind_add_f);
    assign is_exec = (msg_kind_i == kind_exec_e) || (msg_kind_i == kind_exec_c) ||
                     (msg_kind_i == kind_cancel_x);

    assign sel_ref    = in_field(byte_offset_i, off_ref);  // Every kind
    assign sel_side   = is_add && (byte_offset_i == off_side);
    assign sel_shares = is_add ? in_field(byte_offset_i, off_shares_add)
                               : is_exec && in_field(byte_offset_i, off_shares_exec);
    assign sel_stock  = is_add && in_field(byte_offset_i, off_stock);
    assign sel_price  = (is_add || msg_kind_i == kind_exec_c) &&
                        in_field(byte_offset_i, off_price);

    // Strobes are one cycle behind the input
    always_ff @(posedge clk) begin
        byte_q <= data_i;
    end

    //////////////////////////////////////////////////
    // Record assembly
    //////////////////////////////////////////////////

    // Bytes come in order, so shifting in builds each field big-endian
    always_ff @(posedge clk) begin
        if (msg_start_i) begin
            rec_o            <= '0;
            rec_o.order_type <= type_of_kind(msg_kind_i);
        end else if (byte_strobe_i) begin
            if (sel_ref) begin
                rec_o.order_ref <= {rec_o.order_ref[23:0], byte_q};
            end
            if (sel_shares) begin
                rec_o.num_shares <= {rec_o.num_shares[23:0], byte_q};
            end
            if (sel_stock) begin
                rec_o.stock_id <= {rec_o.stock_id[23:0], byte_q};
            end
            if (sel_price) begin
                rec_o.price <= {rec_o.price[23:0], byte_q};
            end
            if (sel_side) begin
                rec_o.buy_sell <= byte_q[0];  // 'S' is odd, 'B' even
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rec_load_o <= 1'b0;
        end else begin
            rec_load_o <= msg_done_i;  // Last byte is in the record now
        end
    end

    // Body bytes only flow for a decoded message
    a_kind_on_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        byte_strobe_i |-> msg_kind_i != kind_none);

endmodule

`default_nettype wire

//--- src/itch_framer.sv
`timescale 1ns/1ps
`default_nettype none

module itch_framer (
    input  wire logic                clk,
    input  wire logic                reset_n,
    input  wire logic [7:0]          data_i,
    input  wire logic                valid_i,
    input  wire logic                rec_full_i,
    output logic                     ready_o,
    output logic                     byte_strobe_o,
    output logic [7:0]               byte_offset_o,
    output itch_msg_pkg::msg_kind_t  msg_kind_o,
    output logic                     msg_start_o,
    output logic                     msg_done_o
);
    import itch_msg_pkg::*;

    typedef enum logic [1:0] {
        st_wait_len,
        st_wait_type,
        st_body,
        st_skip
    } framer_state_t;

    framer_state_t state_q;
    logic [7:0]    remain_q;   // Bytes left including the type byte
    logic [7:0]    offset_q;   // Offset of the next body byte
    logic          done_q;     // Record moving into the output stage
    logic          consume;
    logic          last_byte;
    logic          hold;
    msg_kind_t     type_kind;

    function automatic msg_kind_t decode_kind(input logic [7:0] code);
        case (code)
            type_code_a: return kind_add_a;
            type_code_f: return kind_add_f;
            type_code_e: return kind_exec_e;
            type_code_c: return kind_exec_c;
            type_code_x: return kind_cancel_x;
            type_code_d: return kind_delete_d;
            default:     return kind_none;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Input back-pressure
    //////////////////////////////////////////////////

    assign type_kind = decode_kind(data_i);

    // Next byte closes a relevant message
    assign last_byte = (remain_q == 8'd1) &&
                       ((state_q == st_body) ||
                        (state_q == st_wait_type && type_kind != kind_none));

    // Output slot taken or a record still on its way there
    assign hold    = rec_full_i | done_q;
    assign ready_o = !(last_byte && hold);
    assign consume = valid_i && ready_o;

    //////////////////////////////////////////////////
    // Message FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q       <= st_wait_len;
            remain_q      <= '0;
            offset_q      <= '0;
            done_q        <= 1'b0;
            byte_strobe_o <= 1'b0;
            byte_offset_o <= '0;
            msg_kind_o    <= kind_none;
            msg_start_o   <= 1'b0;
            msg_done_o    <= 1'b0;
        end else begin
            byte_strobe_o <= 1'b0;
            msg_start_o   <= 1'b0;
            msg_done_o    <= 1'b0;
            done_q        <= msg_done_o;
            if (consume) begin
                case (state_q)
                    st_wait_len: begin
                        remain_q <= data_i;
                        if (data_i != 8'd0) begin  // Zero length is dropped
                            state_q <= st_wait_type;
                        end
                    end
                    st_wait_type: begin
                        remain_q   <= remain_q - 8'd1;
                        offset_q   <= 8'd1;
                        msg_kind_o <= type_kind;
                        if (type_kind != kind_none) begin
                            msg_start_o <= 1'b1;
                            msg_done_o  <= last_byte;  // Type-only message
                            state_q     <= last_byte ? st_wait_len : st_body;
                        end else begin
                            state_q <= (remain_q == 8'd1) ? st_wait_len : st_skip;
                        end
                    end
                    st_body: begin
                        remain_q      <= remain_q - 8'd1;
                        offset_q      <= offset_q + 8'd1;
                        byte_strobe_o <= 1'b1;
                        byte_offset_o <= offset_q;
                        msg_done_o    <= last_byte;
                        if (last_byte) begin
                            state_q <= st_wait_len;
                        end
                    end
                    default: begin
                        // Skip body never stalls
                        remain_q <= remain_q - 8'd1;
                        if (remain_q == 8'd1) begin
                            state_q <= st_wait_len;
                        end
                    end
                endcase
            end
        end
    end

    // A finished message never lands on a full output stage
    a_done_not_full: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(msg_done_o) |-> !rec_full_i);

endmodule

`default_nettype wire

//--- src/itch_msg_pkg.sv
`default_nettype none

package itch_msg_pkg;

    // Kind of the message in progress
    // kind_none marks idle time and skipped messages
    typedef enum logic [2:0] {
        kind_none,
        kind_add_a,
        kind_add_f,
        kind_exec_e,
        kind_exec_c,
        kind_cancel_x,
        kind_delete_d
    } msg_kind_t;

    //////////////////////////////////////////////////
    // ASCII message type codes
    //////////////////////////////////////////////////

    localparam logic [7:0] type_code_a = 8'h41;  // Add order
    localparam logic [7:0] type_code_f = 8'h46;  // Add order with MPID
    localparam logic [7:0] type_code_e = 8'h45;  // Order executed
    localparam logic [7:0] type_code_c = 8'h43;  // Executed with price
    localparam logic [7:0] type_code_x = 8'h58;  // Order cancel
    localparam logic [7:0] type_code_d = 8'h44;  // Order delete

    //////////////////////////////////////////////////
    // Field offsets, type byte sits at offset 0
    //////////////////////////////////////////////////

    localparam logic [7:0] off_ref         = 8'd15;  // Low four bytes of the reference
    localparam logic [7:0] off_side        = 8'd19;  // A and F
    localparam logic [7:0] off_shares_add  = 8'd20;  // A and F
    localparam logic [7:0] off_shares_exec = 8'd19;  // E, C and X
    localparam logic [7:0] off_stock       = 8'd24;  // A and F
    localparam logic [7:0] off_price       = 8'd32;  // A, F and C

    // Every captured field is four bytes
    localparam logic [7:0] field_bytes = 8'd4;

endpackage

`default_nettype wire

//--- src/itch_order_out.sv
`timescale 1ns/1ps
`default_nettype none

module itch_order_out (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire order_pkg::order_rec_t  rec_i,
    input  wire logic                   rec_load_i,
    input  wire logic                   ready_i,
    output logic [31:0]                 stock_id_o,
    output logic [31:0]                 order_ref_num_o,
    output logic [31:0]                 num_shares_o,
    output logic [31:0]                 price_o,
    output order_pkg::order_type_t      order_type_o,
    output logic                        buy_sell_o,
    output logic                        valid_o,
    output logic                        rec_full_o
);
    import order_pkg::*;

    order_rec_t hold_q;  // Record waiting for the consumer
    logic       full_q;
    logic       issue;

    assign issue = full_q && ready_i;

    always_ff @(posedge clk) begin
        if (rec_load_i) begin
            hold_q <= rec_i;
        end
    end

    //////////////////////////////////////////////////
    // Full flag and valid pulse
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full_q  <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= issue;  // One pulse per record
            if (rec_load_i) begin
                full_q <= 1'b1;
            end else if (issue) begin
                full_q <= 1'b0;
            end
        end
    end

    // Fields stay put until the next record is loaded
    assign stock_id_o      = hold_q.stock_id;
    assign order_ref_num_o = hold_q.order_ref;
    assign num_shares_o    = hold_q.num_shares;
    assign price_o         = hold_q.price;
    assign order_type_o    = hold_q.order_type;
    assign buy_sell_o      = hold_q.buy_sell;
    assign rec_full_o      = full_q;

    // Framer stall must keep a second record out of the slot
    a_no_overwrite: assert property (@(posedge clk) disable iff (!reset_n)
        rec_load_i |-> !full_q);

endmodule

`default_nettype wire

//--- src/itch_parser_top.sv
`timescale 1ns/1ps
`default_nettype none

module itch_parser_top (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic [7:0]         data_i,
    input  wire logic               valid_i,
    input  wire logic               ready_i,
    output logic                    ready_o,
    output logic [31:0]             stock_id_o,
    output logic [31:0]             order_ref_num_o,
    output logic [31:0]             num_shares_o,
    output logic [31:0]             price_o,
    output order_pkg::order_type_t  order_type_o,
    output logic                    buy_sell_o,
    output logic                    valid_o
);
    import itch_msg_pkg::*;
    import order_pkg::*;

    logic       byte_strobe;
    logic [7:0] byte_offset;
    msg_kind_t  msg_kind;
    logic       msg_start;
    logic       msg_done;
    order_rec_t rec;
    logic       rec_load;
    logic       rec_full;  // Back from the output stage

    //////////////////////////////////////////////////
    // Framer, extractor, output register
    //////////////////////////////////////////////////

    itch_framer i_framer (
        .clk           (clk),
        .reset_n       (reset_n),
        .data_i        (data_i),
        .valid_i       (valid_i),
        .rec_full_i    (rec_full),
        .ready_o       (ready_o),
        .byte_strobe_o (byte_strobe),
        .byte_offset_o (byte_offset),
        .msg_kind_o    (msg_kind),
        .msg_start_o   (msg_start),
        .msg_done_o    (msg_done)
    );

    itch_field_extract i_field_extract (
        .clk           (clk),
        .reset_n       (reset_n),
        .byte_strobe_i (byte_strobe),
        .byte_offset_i (byte_offset),
        .msg_kind_i    (msg_kind),
        .msg_start_i   (msg_start),
        .msg_done_i    (msg_done),
        .data_i        (data_i),
        .rec_o         (rec),
        .rec_load_o    (rec_load)
    );

    itch_order_out i_order_out (
        .clk             (clk),
        .reset_n         (reset_n),
        .rec_i           (rec),
        .rec_load_i      (rec_load),
        .ready_i         (ready_i),
        .stock_id_o      (stock_id_o),
        .order_ref_num_o (order_ref_num_o),
        .num_shares_o    (num_shares_o),
        .price_o         (price_o),
        .order_type_o    (order_type_o),
        .buy_sell_o      (buy_sell_o),
        .valid_o         (valid_o),
        .rec_full_o      (rec_full)
    );

endmodule

`default_nettype wire

//--- src/order_pkg.sv
`default_nettype none

package order_pkg;

    // One-hot order type, zero for an unknown message
    typedef enum logic [3:0] {
        ord_error   = 4'h0,
        ord_add     = 4'h1,
        ord_cancel  = 4'h2,
        ord_execute = 4'h4,
        ord_delete  = 4'h8
    } order_type_t;

    //////////////////////////////////////////////////
    // Order record, 133 bits
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] stock_id;    // First four stock characters
        logic [31:0] order_ref;   // Low four bytes of the reference
        logic [31:0] num_shares;
        logic [31:0] price;
        order_type_t order_type;
        logic        buy_sell;    // 1 for sell
    } order_rec_t;

endpackage

`default_nettype wire

//--- include/itch_tb_msgs.svh
`ifndef ITCH_TB_MSGS_SVH
`define ITCH_TB_MSGS_SVH

// One test message with the record it should produce
typedef struct packed {
    logic [7:0]  code;     // Type byte
    logic [7:0]  len;      // Length byte where zero sends nothing after it
    logic [31:0] ref_num;
    logic [7:0]  side;
    logic [31:0] shares;
    logic [31:0] stock;
    logic [31:0] price;
    logic        has_rec;
    order_rec_t  exp;
} msg_row_t;

localparam int num_msgs = 12;

msg_row_t msg_table [num_msgs];

function automatic order_rec_t exp_rec(input logic [31:0] stock, input logic [31:0] ref_num,
                                       input logic [31:0] shares, input logic [31:0] prc,
                                       input order_type_t kind, input logic sell);
    return '{stock_id: stock, order_ref: ref_num, num_shares: shares, price: prc,
             order_type: kind, buy_sell: sell};
endfunction

// Messages the parser steps over without a record
function automatic msg_row_t skip_row(input logic [7:0] type_byte, input logic [7:0] len_byte);
    return '{code: type_byte, len: len_byte, ref_num: '0, side: '0, shares: '0, stock: '0,
             price: '0, has_rec: 1'b0, exp: '0};
endfunction

task automatic fill_msg_table();
    msg_table[0]  = '{code: type_code_a, len: 8'd36, ref_num: 32'h1000_0001, side: "B",
                      shares: 32'd100, stock: "AAPL", price: 32'd1500000, has_rec: 1'b1,
                      exp: exp_rec("AAPL", 32'h1000_0001, 32'd100, 32'd1500000, ord_add, 1'b0)};
    msg_table[1]  = skip_row(8'h00, 8'd0);  // Zero length byte
    msg_table[2]  = skip_row("S", 8'd12);   // System event
    msg_table[3]  = '{code: type_code_f, len: 8'd40, ref_num: 32'h2000_0002, side: "S",
                      shares: 32'd2500, stock: "MSFT", price: 32'd3101234, has_rec: 1'b1,
                      exp: exp_rec("MSFT", 32'h2000_0002, 32'd2500, 32'd3101234, ord_add, 1'b1)};
    msg_table[4]  = '{code: type_code_e, len: 8'd31, ref_num: 32'hDEAD_BEEF, side: 8'h00,
                      shares: 32'd75, stock: 32'h0, price: 32'h0, has_rec: 1'b1,
                      exp: exp_rec(32'h0, 32'hDEAD_BEEF, 32'd75, 32'h0, ord_execute, 1'b0)};
    msg_table[5]  = skip_row("P", 8'd44);   // Trade message without an order
    msg_table[6]  = '{code: type_code_c, len: 8'd36, ref_num: 32'h0A0B_0C0D, side: 8'h00,
                      shares: 32'd30, stock: 32'h0, price: 32'd999, has_rec: 1'b1,
                      exp: exp_rec(32'h0, 32'h0A0B_0C0D, 32'd30, 32'd999, ord_execute, 1'b0)};
    msg_table[7]  = skip_row(8'h00, 8'd0);
    msg_table[8]  = '{code: type_code_x, len: 8'd23, ref_num: 32'h7F00_00FF, side: 8'h00,
                      shares: 32'd12, stock: 32'h0, price: 32'h0, has_rec: 1'b1,
                      exp: exp_rec(32'h0, 32'h7F00_00FF, 32'd12, 32'h0, ord_cancel, 1'b0)};
    msg_table[9]  = '{code: type_code_d, len: 8'd19, ref_num: 32'h1234_5678, side: 8'h00,
                      shares: 32'h0, stock: 32'h0, price: 32'h0, has_rec: 1'b1,
                      exp: exp_rec(32'h0, 32'h1234_5678, 32'h0, 32'h0, ord_delete, 1'b0)};
    // Type-only messages back to back force a stall on the input
    msg_table[10] = '{code: type_code_d, len: 8'd1, ref_num: 32'h0, side: 8'h00,
                      shares: 32'h0, stock: 32'h0, price: 32'h0, has_rec: 1'b1,
                      exp: exp_rec(32'h0, 32'h0, 32'h0, 32'h0, ord_delete, 1'b0)};
    msg_table[11] = '{code: type_code_x, len: 8'd1, ref_num: 32'h0, side: 8'h00,
                      shares: 32'h0, stock: 32'h0, price: 32'h0, has_rec: 1'b1,
                      exp: exp_rec(32'h0, 32'h0, 32'h0, 32'h0, ord_cancel, 1'b0)};
endtask

`endif

//--- tb/tb_itch_parser.sv
`timescale 1ns/1ps
`default_nettype none

module tb_itch_parser;
    import itch_msg_pkg::*;
    import order_pkg::*;

    localparam int clk_half_ns  = 2;     // 4 ns period
    localparam int reset_cycles = 10;
    localparam int wait_limit   = 200;   // Cycles a byte may wait for ready_o
    localparam int drain_limit  = 2000;

    logic        clk = 1'b0;
    logic        reset_n;
    logic [7:0]  data_i;
    logic        valid_i;
    logic        ready_i;
    logic        ready_o;
    logic [31:0] stock_id_o;
    logic [31:0] order_ref_num_o;
    logic [31:0] num_shares_o;
    logic [31:0] price_o;
    order_type_t order_type_o;
    logic        buy_sell_o;
    logic        valid_o;

    integer      seed = 57;
    order_rec_t  exp_q[$];   // Records still owed by the DUT
    int          errors;
    int          timeouts;
    int          records;
    logic        rand_ready;
    logic        gap_valid;
    logic        watch_ready;
    logic        ready_dropped;

`include "itch_tb_msgs.svh"

    itch_parser_top i_itch_parser_top (
        .clk             (clk),
        .reset_n         (reset_n),
        .data_i          (data_i),
        .valid_i         (valid_i),
        .ready_i         (ready_i),
        .ready_o         (ready_o),
        .stock_id_o      (stock_id_o),
        .order_ref_num_o (order_ref_num_o),
        .num_shares_o    (num_shares_o),
        .price_o         (price_o),
        .order_type_o    (order_type_o),
        .buy_sell_o      (buy_sell_o),
        .valid_o         (valid_o)
    );

    always #clk_half_ns clk = ~clk;

    // Output back-pressure is drawn at the edge and driven 1 ns later
    always @(posedge clk) begin
        logic next_ready;
        next_ready = rand_ready ? (($random(seed) & 1) == 1) : 1'b1;
        #1;
        ready_i = next_ready;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    //////////////////////////////////////////////////
    // Record monitor
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        order_rec_t want;
        if (reset_n && valid_o) begin
            records++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A record came out with no message pending, ref %h", order_ref_num_o);
            end else begin
                want = exp_q.pop_front();
                check_value("stock_id", stock_id_o, want.stock_id);
                check_value("order_ref", order_ref_num_o, want.order_ref);
                check_value("num_shares", num_shares_o, want.num_shares);
                check_value("price", price_o, want.price);
                check_value("order_type", 32'(order_type_o), 32'(want.order_type));
                check_value("buy_sell", 32'(buy_sell_o), 32'(want.buy_sell));
            end
        end
        if (watch_ready && !ready_o) begin
            ready_dropped = 1'b1;
        end
    end

    function automatic logic in_span(input int off, input int base);
        return (off >= base) && (off < base + int'(field_bytes));
    endfunction

    // Big-endian so the first byte on the wire is the top byte
    function automatic logic [7:0] field_byte(input logic [31:0] value, input int off,
                                              input int base);
        return 8'(value >> (8 * (3 - (off - base))));
    endfunction

    function automatic logic [7:0] msg_byte(input msg_row_t row, input int off,
                                            input logic [7:0] filler);
        logic is_add;
        is_add = (row.code == type_code_a) || (row.code == type_code_f);
        if (off == 0) return row.code;
        if (in_span(off, int'(off_ref))) return field_byte(row.ref_num, off, int'(off_ref));
        if (is_add) begin
            if (off == int'(off_side)) return row.side;
            if (in_span(off, int'(off_shares_add)))
                return field_byte(row.shares, off, int'(off_shares_add));
            if (in_span(off, int'(off_stock))) return field_byte(row.stock, off, int'(off_stock));
        end else if (in_span(off, int'(off_shares_exec))) begin
            return field_byte(row.shares, off, int'(off_shares_exec));
        end
        if (in_span(off, int'(off_price))) return field_byte(row.price, off, int'(off_price));
        return filler;
    endfunction

    //////////////////////////////////////////////////
    // Byte driver
    //////////////////////////////////////////////////

    // Called 1 ns after a rising edge and returns at the same point
    task automatic send_byte(input logic [7:0] b);
        int gaps;
        int waited;
        gaps = gap_valid ? ($random(seed) & 3) : 0;
        repeat (gaps) begin
            valid_i = 1'b0;
            data_i  = 8'($random(seed));  // Junk the DUT must ignore
            @(posedge clk);
            #1;
        end
        data_i  = b;
        valid_i = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!ready_o && waited < wait_limit) begin
            waited++;
            @(negedge clk);
        end
        if (!ready_o) begin
            timeouts++;
            $display("Timed out waiting for ready_o with byte %h held", b);
        end
        @(posedge clk);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic send_msg(input msg_row_t row);
        logic [7:0] filler;
        if (row.has_rec) begin
            exp_q.push_back(row.exp);
        end
        send_byte(row.len);
        for (int off = 0; off < int'(row.len) && timeouts == 0; off++) begin
            filler = 8'($random(seed));
            send_byte(msg_byte(row, off, filler));
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timed out with %0d records never delivered", exp_q.size());
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_pass(input logic throttle, input logic gapped);
        rand_ready = throttle;
        gap_valid  = gapped;
        for (int i = 0; i < num_msgs && timeouts == 0; i++) begin
            send_msg(msg_table[i]);
        end
        if (timeouts == 0) begin
            wait_drain();
        end
        rand_ready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        reset_n       = 1'b0;
        data_i        = 8'h00;
        valid_i       = 1'b0;
        ready_i       = 1'b1;
        rand_ready    = 1'b0;
        gap_valid     = 1'b0;
        watch_ready   = 1'b0;
        ready_dropped = 1'b0;
        errors        = 0;
        timeouts      = 0;
        records       = 0;
        fill_msg_table();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(negedge clk);
        check_value("ready_o after reset", 32'(ready_o), 32'd1);
        check_value("valid_o after reset", 32'(valid_o), 32'd0);
        @(posedge clk);
        #1;

        run_pass(1'b0, 1'b0);  // Back to back with the consumer always ready
        watch_ready = 1'b1;
        run_pass(1'b1, 1'b0);  // Consumer stalls about half the time
        watch_ready = 1'b0;
        if (timeouts == 0 && !ready_dropped) begin
            errors++;
            $display("ready_o never went low while ready_i was throttled");
        end
        if (timeouts == 0) begin
            run_pass(1'b0, 1'b1);  // Gaps on valid_i
        end

        $display("Summary: %0d errors, %0d timeouts, %0d records checked",
                 errors, timeouts, records);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
